//--- hw/hdd_bus_pkg.sv
/*
 * CPU-visible register map of the ProDOS block device card.
 * Offsets come from a[3:0] of the device-select range. Offsets 9 to 15 are unused.
 */
`default_nettype none

package hdd_bus_pkg;

    typedef logic [3:0] reg_offset_t;   // Offset within the device window
    typedef logic [7:0] cmd_t;
    typedef logic [7:0] status_t;

    // ------------------------------------------------------------
    // Register offsets
    localparam reg_offset_t REG_EXECUTE    = 4'h0;  // Read runs the latched command
    localparam reg_offset_t REG_STATUS     = 4'h1;
    localparam reg_offset_t REG_COMMAND    = 4'h2;
    localparam reg_offset_t REG_UNIT       = 4'h3;
    localparam reg_offset_t REG_MEM_LOW    = 4'h4;
    localparam reg_offset_t REG_MEM_HIGH   = 4'h5;
    localparam reg_offset_t REG_BLOCK_LOW  = 4'h6;
    localparam reg_offset_t REG_BLOCK_HIGH = 4'h7;
    localparam reg_offset_t REG_NEXT_BYTE  = 4'h8;  // Streams the sector buffer

    // ProDOS command and status codes
    localparam cmd_t    CMD_STATUS     = 8'h00;
    localparam cmd_t    CMD_READ       = 8'h01;
    localparam cmd_t    CMD_WRITE      = 8'h02;
    localparam status_t STATUS_OK      = 8'h00;
    localparam status_t STATUS_ERROR   = 8'h01;
    localparam status_t STATUS_BUSY    = 8'h80;
    localparam status_t STATUS_PROTECT = 8'h2B;

    localparam logic [7:0] BUS_IDLE_DATA = 8'hFF;  // d_out when nothing is read

endpackage

`default_nettype wire

//--- hw/hdd_sector_pkg.sv
/*
 * Sector buffer geometry and the data types of the block path.
 * ProDOS blocks are 512 bytes and addressed by a 16-bit number.
 */
`default_nettype none

package hdd_sector_pkg;

    // ------------------------------------------------------------
    // Data path types
    typedef logic [7:0]  byte_t;
    typedef logic [8:0]  sector_offset_t;  // Byte position inside a sector
    typedef logic [15:0] block_t;          // ProDOS block number

    // Buffer geometry
    localparam int SECTOR_BYTES = 512;

endpackage

`default_nettype wire

//--- hw/hdd_control.sv
/*
 * Access decode, status register and command sequencing of the block device card.
 * An access is one clock with phi0 and a rising device_select.
 * The CPU must leave at least three idle clocks between accesses.
 */
`timescale 1ns/10ps
`default_nettype none

module hdd_control (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  wire                          phi0,
    input  wire                          device_select,
    input  wire                          rd,
    input  wire hdd_bus_pkg::reg_offset_t offset,
    input  wire hdd_sector_pkg::byte_t    d_in,
    input  wire                          hdd_mounted,
    input  wire                          hdd_protect,
    input  wire hdd_sector_pkg::byte_t    reg_q,
    input  wire hdd_sector_pkg::byte_t    stream_q,
    input  wire                          stream_last,
    output logic                         reg_we,
    output logic                         stream_clear,
    output logic                         stream_read,
    output logic                         stream_write,
    output hdd_sector_pkg::byte_t         d_out,
    output logic                         hdd_read,
    output logic                         hdd_write
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ_ACTIVE,
        ST_WRITE_ACTIVE
    } cmd_state_t;

    cmd_state_t           cmd_state;
    hdd_bus_pkg::status_t status;
    hdd_bus_pkg::cmd_t    command;      // Latched at REG_COMMAND write
    logic                 select_d;
    logic                 access;
    logic                 rd_access;
    logic                 wr_access;

    // ------------------------------------------------------------
    // Access decode, one access per select assertion
    assign access    = phi0 && device_select && !select_d;
    assign rd_access = access && rd;
    assign wr_access = access && !rd;

    assign reg_we       = wr_access;                 // Register file picks its own offsets
    assign stream_clear = wr_access && (offset == hdd_bus_pkg::REG_COMMAND);
    assign stream_read  = rd_access && (offset == hdd_bus_pkg::REG_NEXT_BYTE);
    assign stream_write = wr_access && (offset == hdd_bus_pkg::REG_NEXT_BYTE);

    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            select_d  <= 1'b0;
            d_out     <= hdd_bus_pkg::BUS_IDLE_DATA;
            hdd_read  <= 1'b0;
            hdd_write <= 1'b0;
            status    <= hdd_bus_pkg::STATUS_OK;
            command   <= hdd_bus_pkg::CMD_STATUS;
            cmd_state <= ST_IDLE;
        end else begin
            select_d  <= device_select;
            d_out     <= hdd_bus_pkg::BUS_IDLE_DATA;
            hdd_read  <= 1'b0;                       // Strobes last one cycle
            hdd_write <= 1'b0;

            if (rd_access) begin
                case (offset)
                    hdd_bus_pkg::REG_EXECUTE: begin
                        d_out <= status;             // Status from before the access
                        case (command)
                            hdd_bus_pkg::CMD_STATUS:
                                status <= hdd_mounted ? hdd_bus_pkg::STATUS_OK
                                                      : hdd_bus_pkg::STATUS_ERROR;
                            hdd_bus_pkg::CMD_READ: begin
                                if (!hdd_mounted) begin
                                    status    <= hdd_bus_pkg::STATUS_ERROR;
                                    d_out     <= hdd_bus_pkg::STATUS_ERROR;
                                    cmd_state <= ST_IDLE;
                                end else if (cmd_state == ST_READ_ACTIVE) begin
                                    hdd_read <= 1'b1;   // Host fills the buffer
                                end
                            end
                            hdd_bus_pkg::CMD_WRITE: begin
                                if (hdd_protect) begin
                                    status    <= hdd_bus_pkg::STATUS_ERROR;
                                    d_out     <= hdd_bus_pkg::STATUS_PROTECT;
                                    cmd_state <= ST_IDLE;
                                end else if (!hdd_mounted) begin
                                    status    <= hdd_bus_pkg::STATUS_ERROR;
                                    d_out     <= hdd_bus_pkg::STATUS_ERROR;
                                    cmd_state <= ST_IDLE;
                                end else if (cmd_state == ST_WRITE_ACTIVE) begin
                                    hdd_write <= 1'b1;  // Buffer already streamed in
                                    cmd_state <= ST_IDLE;
                                end
                            end
                            default: ;
                        endcase
                    end
                    hdd_bus_pkg::REG_STATUS:
                        d_out <= status;
                    hdd_bus_pkg::REG_NEXT_BYTE: begin
                        d_out <= stream_q;
                        if (stream_last) begin
                            // End of sector releases the busy status
                            status <= hdd_bus_pkg::STATUS_OK;
                            if (cmd_state == ST_READ_ACTIVE)
                                cmd_state <= ST_IDLE;
                        end
                    end
                    hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::REG_UNIT,
                    hdd_bus_pkg::REG_MEM_LOW, hdd_bus_pkg::REG_MEM_HIGH,
                    hdd_bus_pkg::REG_BLOCK_LOW, hdd_bus_pkg::REG_BLOCK_HIGH:
                        d_out <= reg_q;
                    default: ;                       // Unused offsets read idle data
                endcase
            end

            if (wr_access && (offset == hdd_bus_pkg::REG_COMMAND)) begin
                command <= d_in;
                case (d_in)
                    hdd_bus_pkg::CMD_READ: begin
                        status    <= hdd_bus_pkg::STATUS_BUSY;
                        cmd_state <= ST_READ_ACTIVE;
                    end
                    hdd_bus_pkg::CMD_WRITE: begin
                        status    <= hdd_bus_pkg::STATUS_BUSY;
                        cmd_state <= ST_WRITE_ACTIVE;
                    end
                    default: begin
                        status    <= hdd_bus_pkg::STATUS_OK;
                        cmd_state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // ------------------------------------------------------------
    // Host strobes never overlap
    assert property (@(posedge CLK_14M) disable iff (RESET) !(hdd_read && hdd_write));

    // Three idle clocks after each access cover the buffer read latency
    assert property (@(posedge CLK_14M) disable iff (RESET)
        access |-> !$past(access) && !$past(access, 2) && !$past(access, 3));

endmodule

`default_nettype wire

//--- hw/hdd_registers.sv
/*
 * Parameter block registers of the ProDOS interface.
 * Readback covers offsets 2 to 7. Writes elsewhere have no effect.
 */
`timescale 1ns/10ps
`default_nettype none

module hdd_registers (
    input  wire                          CLK_14M,
    input  wire                          RESET,
    input  wire                          we,
    input  wire hdd_bus_pkg::reg_offset_t offset,
    input  wire hdd_sector_pkg::byte_t    d_in,
    output hdd_sector_pkg::byte_t         reg_q,
    output hdd_sector_pkg::block_t        sector
);

    hdd_sector_pkg::byte_t command;     // Copy for readback only
    hdd_sector_pkg::byte_t unit;
    hdd_sector_pkg::byte_t mem_low;
    hdd_sector_pkg::byte_t mem_high;
    hdd_sector_pkg::byte_t block_low;
    hdd_sector_pkg::byte_t block_high;

    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            command    <= '0;
            unit       <= '0;
            mem_low    <= '0;
            mem_high   <= '0;
            block_low  <= '0;
            block_high <= '0;
        end else if (we) begin
            case (offset)
                hdd_bus_pkg::REG_COMMAND:    command    <= d_in;
                hdd_bus_pkg::REG_UNIT:       unit       <= d_in;
                hdd_bus_pkg::REG_MEM_LOW:    mem_low    <= d_in;
                hdd_bus_pkg::REG_MEM_HIGH:   mem_high   <= d_in;
                hdd_bus_pkg::REG_BLOCK_LOW:  block_low  <= d_in;
                hdd_bus_pkg::REG_BLOCK_HIGH: block_high <= d_in;
                default: ;
            endcase
        end
    end

    always_comb begin
        case (offset)
            hdd_bus_pkg::REG_COMMAND:    reg_q = command;
            hdd_bus_pkg::REG_UNIT:       reg_q = unit;
            hdd_bus_pkg::REG_MEM_LOW:    reg_q = mem_low;
            hdd_bus_pkg::REG_MEM_HIGH:   reg_q = mem_high;
            hdd_bus_pkg::REG_BLOCK_LOW:  reg_q = block_low;
            hdd_bus_pkg::REG_BLOCK_HIGH: reg_q = block_high;
            default:                     reg_q = hdd_bus_pkg::BUS_IDLE_DATA;
        endcase
    end

    assign sector = {block_high, block_low};  // Block number to the host

endmodule

`default_nettype wire

//--- hw/sector_buffer.sv
/*
 * True dual-port sector RAM of 2**ADDR_WIDTH bytes, ADDR_WIDTH no larger than 9.
 * Port A serves the host with two clocks of read latency. Port B serves the CPU with one.
 * Contents are not cleared by reset.
 */
`timescale 1ns/10ps
`default_nettype none

module sector_buffer #(
    parameter int ADDR_WIDTH = 9
) (
    input  wire                             CLK_14M,
    input  wire                             a_we,
    input  wire hdd_sector_pkg::sector_offset_t a_addr,
    input  wire hdd_sector_pkg::byte_t       a_di,
    output hdd_sector_pkg::byte_t            a_q,
    input  wire                             b_we,
    input  wire hdd_sector_pkg::sector_offset_t b_addr,
    input  wire hdd_sector_pkg::byte_t       b_di,
    output hdd_sector_pkg::byte_t            b_q
);

    hdd_sector_pkg::byte_t mem [0:(1 << ADDR_WIDTH) - 1];
    hdd_sector_pkg::byte_t a_ram_q;     // Raw port A read, staged once more

    always_ff @(posedge CLK_14M) begin
        if (a_we)
            mem[a_addr[ADDR_WIDTH-1:0]] <= a_di;
        if (b_we)
            mem[b_addr[ADDR_WIDTH-1:0]] <= b_di;
        a_ram_q <= mem[a_addr[ADDR_WIDTH-1:0]];
        a_q     <= a_ram_q;
        b_q     <= mem[b_addr[ADDR_WIDTH-1:0]];
    end

    // Host and CPU never store to the same byte in one clock
    assert property (@(posedge CLK_14M)
        !(a_we && b_we && (a_addr[ADDR_WIDTH-1:0] == b_addr[ADDR_WIDTH-1:0])));

endmodule

`default_nettype wire

//--- hw/byte_stream.sv
/*
 * NEXT BYTE offset counter and CPU side of the sector buffer.
 * The offset wraps after the last byte of the buffer or sector, whichever is smaller.
 * A read byte is valid two clocks after the offset moves.
 */
`timescale 1ns/10ps
`default_nettype none

module byte_stream #(
    parameter int ADDR_WIDTH = 9
) (
    input  wire                             CLK_14M,
    input  wire                             RESET,
    input  wire                             clear,
    input  wire                             read,
    input  wire                             write,
    input  wire hdd_sector_pkg::byte_t       d_in,
    input  wire hdd_sector_pkg::byte_t       buf_q,
    output hdd_sector_pkg::sector_offset_t   buf_addr,
    output logic                            buf_we,
    output hdd_sector_pkg::byte_t            buf_di,
    output hdd_sector_pkg::byte_t            stream_q,
    output logic                            last
);

    localparam int DEPTH      = 1 << ADDR_WIDTH;
    localparam int LAST_INDEX = (DEPTH < hdd_sector_pkg::SECTOR_BYTES ?
                                 DEPTH : hdd_sector_pkg::SECTOR_BYTES) - 1;
    localparam logic [ADDR_WIDTH-1:0] LAST_OFFSET = ADDR_WIDTH'(LAST_INDEX);

    logic [ADDR_WIDTH-1:0] offset;
    logic [ADDR_WIDTH-1:0] wr_addr;     // Offset captured with the CPU write

    // ------------------------------------------------------------
    always_ff @(posedge CLK_14M) begin
        if (RESET) begin
            offset <= '0;
            buf_we <= 1'b0;
        end else begin
            buf_we <= write;
            if (clear)
                offset <= '0;                        // New command restarts the sector
            else if (read || write)
                offset <= last ? '0 : offset + 1'b1;
        end
    end

    always_ff @(posedge CLK_14M) begin
        if (write) begin
            wr_addr <= offset;
            buf_di  <= d_in;
        end
        stream_q <= buf_q;                           // Stage port B for the next access
    end

    assign last     = (offset == LAST_OFFSET);
    assign buf_addr = buf_we ? hdd_sector_pkg::sector_offset_t'(wr_addr)
                             : hdd_sector_pkg::sector_offset_t'(offset);

endmodule

`default_nettype wire

//--- hw/hdd.sv
/*
 * ProDOS block device card for an Apple II style bus, without slot ROM.
 * The host serves hdd_read and hdd_write through the ram_* port.
 */
`timescale 1ns/10ps
`default_nettype none

module hdd #(
    parameter int ADDR_WIDTH = 9        // log2 of the sector buffer depth
) (
    input  wire                             CLK_14M,
    input  wire                             RESET,
    input  wire                             phi0,
    input  wire                             device_select,
    input  wire [15:0]                      a,
    input  wire                             rd,
    input  wire hdd_sector_pkg::byte_t       d_in,
    output hdd_sector_pkg::byte_t            d_out,
    output hdd_sector_pkg::block_t           sector,
    output logic                            hdd_read,
    output logic                            hdd_write,
    input  wire                             hdd_mounted,
    input  wire                             hdd_protect,
    input  wire hdd_sector_pkg::sector_offset_t ram_addr,
    input  wire hdd_sector_pkg::byte_t       ram_di,
    input  wire                             ram_we,
    output hdd_sector_pkg::byte_t            ram_do
);

    // ------------------------------------------------------------
    logic                           reg_we, stream_clear, stream_read, stream_write;
    logic                           stream_last, buf_we;
    hdd_sector_pkg::byte_t          reg_q, stream_q, buf_q, buf_di;
    hdd_sector_pkg::sector_offset_t buf_addr;

    hdd_control control_inst (
        .CLK_14M, .RESET, .phi0, .device_select, .rd,
        .offset(a[3:0]), .d_in, .hdd_mounted, .hdd_protect,
        .reg_q, .stream_q, .stream_last, .reg_we,
        .stream_clear, .stream_read, .stream_write,
        .d_out, .hdd_read, .hdd_write
    );

    hdd_registers registers_inst (
        .CLK_14M, .RESET, .we(reg_we), .offset(a[3:0]), .d_in, .reg_q, .sector
    );

    sector_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) buffer_inst (
        .CLK_14M,
        .a_we(ram_we), .a_addr(ram_addr), .a_di(ram_di), .a_q(ram_do),   // Host side
        .b_we(buf_we), .b_addr(buf_addr), .b_di(buf_di), .b_q(buf_q)      // CPU side
    );

    byte_stream #(.ADDR_WIDTH(ADDR_WIDTH)) stream_inst (
        .CLK_14M, .RESET,
        .clear(stream_clear), .read(stream_read), .write(stream_write),
        .d_in, .buf_q, .buf_addr, .buf_we, .buf_di,
        .stream_q, .last(stream_last)
    );

endmodule

`default_nettype wire

//--- test/tb_hdd.sv
/*
 * Self-checking testbench for the ProDOS block device card.
 * Every CPU access is followed by three idle clocks, as the card requires.
 */
`timescale 1ns/10ps
`default_nettype none

module tb_hdd;

    localparam logic [31:0] SEED       = 32'h8d1c;
    localparam int          TEST_COUNT = 6;
    // About 1150 accesses of 4 clocks and 2100 host clocks stay far below the limit
    localparam int          TIMEOUT    = 40000;

    logic                           CLK_14M = 1'b0;
    logic                           RESET, phi0, device_select, rd;
    logic [15:0]                    a;
    hdd_sector_pkg::byte_t          d_in, d_out, ram_di, ram_do;
    hdd_sector_pkg::block_t         sector;
    logic                           hdd_read, hdd_write, hdd_mounted, hdd_protect, ram_we;
    hdd_sector_pkg::sector_offset_t ram_addr;

    // Reference model state
    hdd_bus_pkg::status_t  m_status;
    hdd_bus_pkg::cmd_t     m_cmd;
    hdd_sector_pkg::byte_t m_regs [0:15];
    hdd_sector_pkg::byte_t m_buf [0:hdd_sector_pkg::SECTOR_BYTES-1];
    int                    m_offset;

    logic [31:0] lfsr = SEED;
    int          cycles = 0;
    int          errors = 0;
    int          test_errors = 0;
    int          tests_run = 0;
    int          tests_failed = 0;

    hdd #(.ADDR_WIDTH(9)) hdd_inst (
        .CLK_14M, .RESET, .phi0, .device_select, .a, .rd, .d_in, .d_out, .sector,
        .hdd_read, .hdd_write, .hdd_mounted, .hdd_protect,
        .ram_addr, .ram_di, .ram_we, .ram_do
    );

    always #20 CLK_14M = ~CLK_14M;

    always @(posedge CLK_14M) begin
        cycles++;
        if (cycles >= TIMEOUT) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT);
            $display("Verification failed");
            $finish;
        end
    end

    // Galois LFSR stepped once per bit taken
    function automatic hdd_sector_pkg::byte_t rand_bits(input int n);
        hdd_sector_pkg::byte_t v;
        int                    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h80200003 : lfsr >> 1;
            v = {v[6:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (test_errors != 0)
            tests_failed++;
        $display("test %0d %-20s %s, %0d mismatches", tests_run, name,
                 (test_errors == 0) ? "ok" : "FAILED", test_errors);
        test_errors = 0;
    endtask

    // ------------------------------------------------------------
    // Reference model of one CPU access
    task automatic model_access(input logic is_rd, input hdd_bus_pkg::reg_offset_t off,
                                input hdd_sector_pkg::byte_t data,
                                output hdd_sector_pkg::byte_t q,
                                output logic rd_strobe, output logic wr_strobe);
        q = hdd_bus_pkg::BUS_IDLE_DATA;
        rd_strobe = 1'b0;
        wr_strobe = 1'b0;
        if (is_rd) begin
            if (off == hdd_bus_pkg::REG_EXECUTE) begin
                q = m_status;                       // Status before the command runs
                if (m_cmd == hdd_bus_pkg::CMD_STATUS) begin
                    m_status = hdd_mounted ? hdd_bus_pkg::STATUS_OK : hdd_bus_pkg::STATUS_ERROR;
                end else if (m_cmd == hdd_bus_pkg::CMD_READ) begin
                    if (!hdd_mounted) begin
                        q = hdd_bus_pkg::STATUS_ERROR;
                        m_status = hdd_bus_pkg::STATUS_ERROR;
                    end else
                        rd_strobe = 1'b1;
                end else if (m_cmd == hdd_bus_pkg::CMD_WRITE) begin
                    if (hdd_protect) begin
                        q = hdd_bus_pkg::STATUS_PROTECT;
                        m_status = hdd_bus_pkg::STATUS_ERROR;
                    end else if (!hdd_mounted) begin
                        q = hdd_bus_pkg::STATUS_ERROR;
                        m_status = hdd_bus_pkg::STATUS_ERROR;
                    end else
                        wr_strobe = 1'b1;
                end
            end else if (off == hdd_bus_pkg::REG_STATUS) begin
                q = m_status;
            end else if (off >= hdd_bus_pkg::REG_COMMAND && off <= hdd_bus_pkg::REG_BLOCK_HIGH) begin
                q = m_regs[off];
            end else if (off == hdd_bus_pkg::REG_NEXT_BYTE) begin
                q = m_buf[m_offset];
                if (m_offset == hdd_sector_pkg::SECTOR_BYTES - 1)
                    m_status = hdd_bus_pkg::STATUS_OK;  // Sector fully read
                m_offset = (m_offset + 1) % hdd_sector_pkg::SECTOR_BYTES;
            end
        end else if (off == hdd_bus_pkg::REG_COMMAND) begin
            m_cmd = data;
            m_regs[off] = data;
            m_status = (data == hdd_bus_pkg::CMD_READ || data == hdd_bus_pkg::CMD_WRITE) ?
                       hdd_bus_pkg::STATUS_BUSY : hdd_bus_pkg::STATUS_OK;
            m_offset = 0;
        end else if (off >= hdd_bus_pkg::REG_UNIT && off <= hdd_bus_pkg::REG_BLOCK_HIGH) begin
            m_regs[off] = data;
        end else if (off == hdd_bus_pkg::REG_NEXT_BYTE) begin
            m_buf[m_offset] = data;
            m_offset = (m_offset + 1) % hdd_sector_pkg::SECTOR_BYTES;
        end
    endtask

    // ------------------------------------------------------------
    // One phi0 access followed by three idle clocks
    task automatic access(input logic is_rd, input hdd_bus_pkg::reg_offset_t off,
                          input hdd_sector_pkg::byte_t data);
        hdd_sector_pkg::byte_t exp_q;
        logic                  exp_rd;
        logic                  exp_wr;
        @(posedge CLK_14M);
        phi0          <= 1'b1;
        device_select <= 1'b1;
        rd            <= is_rd;
        a             <= {12'h000, off};
        d_in          <= data;
        @(posedge CLK_14M);
        phi0          <= 1'b0;
        device_select <= 1'b0;
        rd            <= 1'b1;
        @(negedge CLK_14M);
        model_access(is_rd, off, data, exp_q, exp_rd, exp_wr);
        check("d_out", 16'(d_out), 16'(exp_q));
        check("hdd_read", 16'(hdd_read), 16'(exp_rd));
        check("hdd_write", 16'(hdd_write), 16'(exp_wr));
        repeat (2) begin
            @(posedge CLK_14M);
            @(negedge CLK_14M);
            check("d_out idle", 16'(d_out), 16'(hdd_bus_pkg::BUS_IDLE_DATA));
            check("hdd_read idle", 16'(hdd_read), 16'h0000);
            check("hdd_write idle", 16'(hdd_write), 16'h0000);
        end
    endtask

    task automatic set_drive_state(input logic mounted, input logic protect);
        @(posedge CLK_14M);
        hdd_mounted <= mounted;
        hdd_protect <= protect;
    endtask

    task automatic host_fill();
        hdd_sector_pkg::byte_t v;
        int                    i;
        for (i = 0; i < hdd_sector_pkg::SECTOR_BYTES; i++) begin
            v = rand_bits(8);
            m_buf[i] = v;
            @(posedge CLK_14M);
            ram_we   <= 1'b1;
            ram_addr <= hdd_sector_pkg::sector_offset_t'(i);
            ram_di   <= v;
        end
        @(posedge CLK_14M);
        ram_we <= 1'b0;
    endtask

    task automatic host_readback();
        int i;
        for (i = 0; i < hdd_sector_pkg::SECTOR_BYTES; i++) begin
            @(posedge CLK_14M);
            ram_addr <= hdd_sector_pkg::sector_offset_t'(i);
            @(posedge CLK_14M);
            @(posedge CLK_14M);
            @(negedge CLK_14M);                     // Two clocks of host read latency
            check("ram_do", 16'(ram_do), 16'(m_buf[i]));
        end
    endtask

    // ------------------------------------------------------------
    initial begin
        int r;
        int off;
        hdd_sector_pkg::byte_t v;
        RESET <= 1'b1;
        phi0 <= 1'b0;
        device_select <= 1'b0;
        rd <= 1'b1;
        a <= '0;
        d_in <= '0;
        hdd_mounted <= 1'b1;
        hdd_protect <= 1'b0;
        ram_addr <= '0;
        ram_di <= '0;
        ram_we <= 1'b0;
        m_status = hdd_bus_pkg::STATUS_OK;
        m_cmd = hdd_bus_pkg::CMD_STATUS;
        m_offset = 0;
        for (off = 0; off < 16; off++)
            m_regs[off] = '0;
        repeat (4) @(posedge CLK_14M);
        RESET <= 1'b0;

        for (r = 0; r < 8; r++) begin
            for (off = 3; off <= 7; off++)
                access(1'b0, hdd_bus_pkg::reg_offset_t'(off), rand_bits(8));
            for (off = 2; off <= 7; off++)
                access(1'b1, hdd_bus_pkg::reg_offset_t'(off), 8'h00);
            check("sector", sector, {m_regs[hdd_bus_pkg::REG_BLOCK_HIGH],
                                     m_regs[hdd_bus_pkg::REG_BLOCK_LOW]});
        end
        end_test("register readback");

        host_fill();
        access(1'b0, hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::CMD_READ);
        access(1'b1, hdd_bus_pkg::REG_COMMAND, 8'h00);
        access(1'b1, hdd_bus_pkg::REG_STATUS, 8'h00);
        access(1'b1, hdd_bus_pkg::REG_EXECUTE, 8'h00);
        repeat (hdd_sector_pkg::SECTOR_BYTES) access(1'b1, hdd_bus_pkg::REG_NEXT_BYTE, 8'h00);
        access(1'b1, hdd_bus_pkg::REG_STATUS, 8'h00);
        end_test("block read");

        access(1'b0, hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::CMD_WRITE);
        repeat (hdd_sector_pkg::SECTOR_BYTES)
            access(1'b0, hdd_bus_pkg::REG_NEXT_BYTE, rand_bits(8));
        access(1'b1, hdd_bus_pkg::REG_EXECUTE, 8'h00);
        host_readback();
        end_test("block write");

        access(1'b0, hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::CMD_WRITE);
        set_drive_state(1'b1, 1'b1);
        access(1'b1, hdd_bus_pkg::REG_EXECUTE, 8'h00);
        access(1'b1, hdd_bus_pkg::REG_STATUS, 8'h00);
        set_drive_state(1'b0, 1'b0);
        access(1'b0, hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::CMD_READ);
        access(1'b1, hdd_bus_pkg::REG_EXECUTE, 8'h00);
        access(1'b1, hdd_bus_pkg::REG_STATUS, 8'h00);
        set_drive_state(1'b1, 1'b0);
        end_test("protect and unmounted");

        access(1'b0, hdd_bus_pkg::REG_COMMAND, hdd_bus_pkg::CMD_STATUS);
        for (r = 0; r < 16; r++) begin
            v = rand_bits(1);
            set_drive_state(v[0], 1'b0);
            access(1'b1, hdd_bus_pkg::REG_EXECUTE, 8'h00);
            access(1'b1, hdd_bus_pkg::REG_STATUS, 8'h00);
        end
        set_drive_state(1'b1, 1'b0);
        end_test("status command");

        for (off = 9; off <= 15; off++)
            access(1'b1, hdd_bus_pkg::reg_offset_t'(off), 8'h00);
        end_test("unused offsets");

        $display("%0d of %0d tests failed, %0d mismatches in total",
                 tests_failed, tests_run, errors);
        if (errors == 0 && tests_run == TEST_COUNT) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/hdd_bus_pkg.sv
hw/hdd_sector_pkg.sv
hw/hdd_control.sv
hw/hdd_registers.sv
hw/sector_buffer.sv
hw/byte_stream.sv
hw/hdd.sv
test/tb_hdd.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_hdd
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)
